//--- Bender.yml
package:
  name: pvr_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pvr_pkg.sv
      - design/vram_rd_if.sv
      - design/pvr_regs.sv
      - design/pal_ram.sv
      - design/region_walker.sv
      - design/list_fetcher.sv
      - design/vram_arbiter.sv
      - design/pvr_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/pvr_checker.sv
      - verif/pvr_tb.sv

//--- design/list_fetcher.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module list_fetcher import pvr_pkg::*; (
	input  logic                   clock,
	input  logic                   reset_n,
	input  logic                   tile_valid,
	input  tile_desc_t             tile,
	output logic                   tile_credit,
	vram_rd_if.requester           ram,
	input  logic                   walk_done,
	output logic                   out_valid,
	output logic [5:0]             out_tile_x,
	output logic [5:0]             out_tile_y,
	output logic [`PVR_DATA_W-1:0] out_opb_word,
	input  logic                   out_credit,
	output logic                   render_done
);
	localparam int QD = `TILE_CREDITS; // queue never overflows, walker holds the credits
	localparam int PW = $clog2(QD);
	localparam int QW = $clog2(QD + 1);
	localparam int CW = $clog2(`OUT_CREDITS + 1);

	tile_desc_t             queue [QD];
	logic [PW-1:0]          wr_ptr;
	logic [PW-1:0]          rd_ptr;
	logic [QW-1:0]          q_count;
	tile_desc_t             head;
	logic                   rd_req;
	logic                   rd_busy;   // read requested or in flight
	logic                   have_word; // head word fetched, waiting for a credit
	logic [`PVR_DATA_W-1:0] word_q;
	logic [CW-1:0]          credits;
	logic                   emit;
	logic                   done_seen; // walker finished, drain the queue

	assign head     = queue[rd_ptr];
	assign ram.req  = rd_req;
	assign ram.addr = head.opaque_ptr; // head is not popped while a read is open
	assign emit     = have_word && (credits != '0);

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			q_count     <= '0;
			rd_req      <= 1'b0;
			rd_busy     <= 1'b0;
			have_word   <= 1'b0;
			credits     <= CW'(`OUT_CREDITS);
			out_valid   <= 1'b0;
			tile_credit <= 1'b0;
			done_seen   <= 1'b0;
			render_done <= 1'b0;
		end else begin
			out_valid   <= emit;
			tile_credit <= emit; // tile retired, walker may send another
			render_done <= 1'b0;
			credits     <= credits + CW'(out_credit) - CW'(emit);
			q_count     <= q_count + QW'(tile_valid) - QW'(emit);
			if (tile_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (emit) begin
				rd_ptr    <= rd_ptr + 1'b1;
				have_word <= 1'b0;
			end
			if (q_count != '0 && !rd_busy && !have_word) begin
				rd_req  <= 1'b1; // fetch for the new head
				rd_busy <= 1'b1;
			end
			if (ram.gnt)
				rd_req <= 1'b0;
			if (ram.rvalid) begin
				have_word <= 1'b1;
				rd_busy   <= 1'b0;
			end
			if (walk_done)
				done_seen <= 1'b1;
			else if (done_seen && q_count == '0) begin
				render_done <= 1'b1; // last tile already emitted
				done_seen   <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (tile_valid)
			queue[wr_ptr] <= tile;
		if (ram.rvalid)
			word_q <= ram.rdata;
		if (emit) begin
			out_tile_x   <= head.tile_x;
			out_tile_y   <= head.tile_y;
			out_opb_word <= word_q;
		end
	end

endmodule

//--- design/pal_ram.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module pal_ram (
	input  logic                          clock,
	input  logic [$clog2(`PAL_DEPTH)-1:0] addr,
	input  logic [`PVR_DATA_W-1:0]        din,
	input  logic                          we,
	output logic [`PVR_DATA_W-1:0]        dout
);
	logic [`PVR_DATA_W-1:0] mem [`PAL_DEPTH]; // palette entries

	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= din;
		dout <= mem[addr]; // free-running registered read, old data on a write
	end

endmodule

//--- design/pvr_core.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module pvr_core import pvr_pkg::*; (
	input  logic                     clock,
	input  logic                     reset_n,
	input  logic                     pvr_reg_cs,
	input  logic [`PVR_ADDR_W-1:0]   pvr_addr,
	input  logic [`PVR_DATA_W-1:0]   pvr_din,
	input  logic                     pvr_rd,
	input  logic                     pvr_wr,
	output logic [`PVR_DATA_W-1:0]   pvr_dout,
	output logic                     vram_rd,
	output logic [`VRAM_PORT_AW-1:0] vram_addr,
	input  logic                     vram_wait,
	input  logic                     vram_valid,
	input  logic [`VRAM_BUS_W-1:0]   vram_din,
	output logic                     out_valid,
	output logic [5:0]               out_tile_x,
	output logic [5:0]               out_tile_y,
	output logic [`PVR_DATA_W-1:0]   out_opb_word,
	input  logic                     out_credit,
	output logic                     render_done
);
	vram_addr_t                        region_base;
	logic                              start;
	logic [$clog2(`PAL_DEPTH)-1:0]     pal_addr;
	logic [`PVR_DATA_W-1:0]            pal_din;
	logic                              pal_we;
	logic [`PVR_DATA_W-1:0]            pal_dout;
	logic                              tile_valid; // walker -> fetcher
	tile_desc_t                        tile;
	logic                              tile_credit;
	logic                              walk_done;

	vram_rd_if ra_bus (); // walker reads
	vram_rd_if lf_bus (); // fetcher reads

	pvr_regs regs_inst (
		.clock(clock),
		.reset_n(reset_n),
		.pvr_reg_cs(pvr_reg_cs),
		.pvr_addr(pvr_addr),
		.pvr_din(pvr_din),
		.pvr_rd(pvr_rd),
		.pvr_wr(pvr_wr),
		.pvr_dout(pvr_dout),
		.region_base(region_base),
		.start(start),
		.pal_addr(pal_addr),
		.pal_din(pal_din),
		.pal_we(pal_we),
		.pal_dout(pal_dout)
	);

	pal_ram pal_inst (
		.clock(clock),
		.addr(pal_addr),
		.din(pal_din),
		.we(pal_we),
		.dout(pal_dout)
	);

	region_walker walker_inst (
		.clock(clock),
		.reset_n(reset_n),
		.start(start),
		.region_base(region_base),
		.ram(ra_bus.requester),
		.tile_valid(tile_valid),
		.tile(tile),
		.tile_credit(tile_credit),
		.walk_done(walk_done)
	);

	list_fetcher fetcher_inst (
		.clock(clock),
		.reset_n(reset_n),
		.tile_valid(tile_valid),
		.tile(tile),
		.tile_credit(tile_credit),
		.ram(lf_bus.requester),
		.walk_done(walk_done),
		.out_valid(out_valid),
		.out_tile_x(out_tile_x),
		.out_tile_y(out_tile_y),
		.out_opb_word(out_opb_word),
		.out_credit(out_credit),
		.render_done(render_done)
	);

	vram_arbiter arb_inst (
		.clock(clock),
		.reset_n(reset_n),
		.ra(ra_bus.arbiter),
		.lf(lf_bus.arbiter),
		.vram_rd(vram_rd),
		.vram_addr(vram_addr),
		.vram_wait(vram_wait),
		.vram_valid(vram_valid),
		.vram_din(vram_din)
	);

endmodule

//--- design/pvr_defines.svh
`ifndef PVR_DEFINES_SVH
`define PVR_DEFINES_SVH

// widths
`define PVR_ADDR_W   16 // host bus address
`define PVR_DATA_W   32 // host register width
`define VRAM_ADDR_W  24 // vram byte address
`define VRAM_BUS_W   64 // vram data bus
`define VRAM_PORT_AW 22 // address leaving the core, lane chosen by bit 22

// host register offsets
`define PVR_ID_addr            16'h0000 // R   device id
`define PVR_REVISION_addr      16'h0004 // R   revision
`define PVR_SOFTRESET_addr     16'h0008 // RW  core and TA soft reset
`define PVR_STARTRENDER_addr   16'h0014 // RW  write kicks the region walker
`define PVR_REGION_BASE_addr   16'h002C // RW  region array base
`define PVR_ISP_BACKGND_D_addr 16'h0088 // RW  background depth
`define PVR_ISP_BACKGND_T_addr 16'h008C // RW  background tag

`define PVR_PAL_PAGE 4'h1 // addr[15:12] of the palette window

// fixed read-only values
`define PVR_ID_VALUE       32'h17FD11DB
`define PVR_REVISION_VALUE 32'h00000011

`define PAL_DEPTH    1024 // palette words
`define TILE_CREDITS 2    // walker -> fetcher, also fetcher queue depth
`define OUT_CREDITS  2    // fetcher -> consumer

`endif

//--- design/pvr_pkg.sv
`include "pvr_defines.svh"

package pvr_pkg;

	typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t; // byte address in vram

	// one tile handed from walker to fetcher
	typedef struct packed {
		logic [5:0] tile_x;
		logic [5:0] tile_y;
		vram_addr_t opaque_ptr; // first opaque object-pointer word
	} tile_desc_t;

	// region entry word 0
	typedef struct packed {
		logic        last;    // final entry of the array
		logic [16:0] rsvd_hi;
		logic [5:0]  tile_y;
		logic [5:0]  tile_x;
		logic [1:0]  rsvd_lo;
	} ra_ctrl_t;

	// region entry word 1
	typedef struct packed {
		logic       empty; // no opaque list for this tile
		logic [6:0] rsvd;
		vram_addr_t addr;
	} ra_ptr_t;

	typedef enum logic [1:0] {ws_idle, ws_ctrl, ws_ptr, ws_credit} walk_state_t;

	typedef enum logic {own_ra, own_lf} vram_owner_t; // who holds the vram read

endpackage

//--- design/pvr_regs.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module pvr_regs import pvr_pkg::*; (
	input  logic                              clock,
	input  logic                              reset_n,
	input  logic                              pvr_reg_cs,
	input  logic [`PVR_ADDR_W-1:0]            pvr_addr,
	input  logic [`PVR_DATA_W-1:0]            pvr_din,
	input  logic                              pvr_rd,
	input  logic                              pvr_wr,
	output logic [`PVR_DATA_W-1:0]            pvr_dout,
	output vram_addr_t                        region_base,
	output logic                              start,
	output logic [$clog2(`PAL_DEPTH)-1:0]     pal_addr,
	output logic [`PVR_DATA_W-1:0]            pal_din,
	output logic                              pal_we,
	input  logic [`PVR_DATA_W-1:0]            pal_dout
);
	logic [`PVR_DATA_W-1:0] soft_reset;
	logic [`PVR_DATA_W-1:0] start_render;
	logic [`PVR_DATA_W-1:0] region_base_q;
	logic [`PVR_DATA_W-1:0] isp_backgnd_d;
	logic [`PVR_DATA_W-1:0] isp_backgnd_t;
	logic [`PVR_DATA_W-1:0] reg_rdata; // register side of the read mux
	logic                   pal_sel;
	logic                   host_wr;
	logic                   host_rd;
	logic                   pal_rd_q; // last read hit the palette page

	assign pal_sel = (pvr_addr[`PVR_ADDR_W-1:`PVR_ADDR_W-4] == `PVR_PAL_PAGE);
	assign host_wr = pvr_reg_cs && pvr_wr;
	assign host_rd = pvr_reg_cs && pvr_rd;

	assign pal_addr = pvr_addr[$clog2(`PAL_DEPTH)+1:2]; // word index inside the page
	assign pal_din  = pvr_din;
	assign pal_we   = host_wr && pal_sel;

	assign region_base = region_base_q[`VRAM_ADDR_W-1:0]; // upper bits only read back
	assign pvr_dout    = pal_rd_q ? pal_dout : reg_rdata;  // both sides already registered

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			soft_reset    <= '0;
			start_render  <= '0;
			region_base_q <= '0;
			isp_backgnd_d <= '0;
			isp_backgnd_t <= '0;
			start         <= 1'b0;
			pal_rd_q      <= 1'b0;
		end else begin
			start <= host_wr && (pvr_addr == `PVR_STARTRENDER_addr); // one cycle after the write
			if (host_rd)
				pal_rd_q <= pal_sel;
			if (host_wr) begin
				case (pvr_addr) // id and revision fall to default
					`PVR_SOFTRESET_addr:     soft_reset    <= pvr_din;
					`PVR_STARTRENDER_addr:   start_render  <= pvr_din;
					`PVR_REGION_BASE_addr:   region_base_q <= pvr_din;
					`PVR_ISP_BACKGND_D_addr: isp_backgnd_d <= pvr_din;
					`PVR_ISP_BACKGND_T_addr: isp_backgnd_t <= pvr_din;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (host_rd) begin
			case (pvr_addr)
				`PVR_ID_addr:            reg_rdata <= `PVR_ID_VALUE;
				`PVR_REVISION_addr:      reg_rdata <= `PVR_REVISION_VALUE;
				`PVR_SOFTRESET_addr:     reg_rdata <= soft_reset;
				`PVR_STARTRENDER_addr:   reg_rdata <= start_render;
				`PVR_REGION_BASE_addr:   reg_rdata <= region_base_q;
				`PVR_ISP_BACKGND_D_addr: reg_rdata <= isp_backgnd_d;
				`PVR_ISP_BACKGND_T_addr: reg_rdata <= isp_backgnd_t;
				default:                 reg_rdata <= '0; // unmapped
			endcase
		end
	end

endmodule

//--- design/region_walker.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module region_walker import pvr_pkg::*; (
	input  logic         clock,
	input  logic         reset_n,
	input  logic         start,
	input  vram_addr_t   region_base,
	vram_rd_if.requester ram,
	output logic         tile_valid,
	output tile_desc_t   tile,
	input  logic         tile_credit,
	output logic         walk_done
);
	localparam int CW = $clog2(`TILE_CREDITS + 1);

	walk_state_t   state;
	vram_addr_t    entry_addr; // word 0 of the current entry
	vram_addr_t    rd_addr;
	logic          rd_req;
	ra_ctrl_t      ctrl_q;
	ra_ptr_t       ptr_w;
	logic          tile_live;  // held tile has an opaque list
	logic [CW-1:0] credits;
	logic          step;       // leave ws_credit this cycle
	logic          send;

	assign ram.req  = rd_req;
	assign ram.addr = rd_addr;
	assign ptr_w    = ram.rdata;

	// empty tiles pass without a credit, live ones wait for one
	assign step = (state == ws_credit) && (!tile_live || credits != '0);
	assign send = step && tile_live;

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			state      <= ws_idle;
			entry_addr <= '0;
			rd_addr    <= '0;
			rd_req     <= 1'b0;
			tile_live  <= 1'b0;
			tile_valid <= 1'b0;
			walk_done  <= 1'b0;
			credits    <= CW'(`TILE_CREDITS);
		end else begin
			tile_valid <= send;
			walk_done  <= 1'b0;
			credits    <= credits + CW'(tile_credit) - CW'(send);
			if (ram.gnt)
				rd_req <= 1'b0; // addr stays put until rvalid
			case (state)
				ws_idle: begin
					if (start) begin // a start while busy never reaches here
						entry_addr <= region_base;
						rd_addr    <= region_base;
						rd_req     <= 1'b1;
						state      <= ws_ctrl;
					end
				end
				ws_ctrl: begin
					if (ram.rvalid) begin
						rd_addr <= entry_addr + vram_addr_t'(4); // pointer word
						rd_req  <= 1'b1;
						state   <= ws_ptr;
					end
				end
				ws_ptr: begin
					if (ram.rvalid) begin
						tile_live <= !ptr_w.empty;
						state     <= ws_credit;
					end
				end
				ws_credit: begin
					if (step) begin
						if (ctrl_q.last) begin
							walk_done <= 1'b1; // same cycle as the final tile_valid
							state     <= ws_idle;
						end else begin
							entry_addr <= entry_addr + vram_addr_t'(8); // entries are 8 bytes
							rd_addr    <= entry_addr + vram_addr_t'(8);
							rd_req     <= 1'b1;
							state      <= ws_ctrl;
						end
					end
				end
				default: state <= ws_idle;
			endcase
		end
	end

	// entry payload, only meaningful while the fsm says so
	always_ff @(posedge clock) begin
		if (state == ws_ctrl && ram.rvalid)
			ctrl_q <= ram.rdata;
		if (state == ws_ptr && ram.rvalid) begin
			tile.tile_x     <= ctrl_q.tile_x;
			tile.tile_y     <= ctrl_q.tile_y;
			tile.opaque_ptr <= ptr_w.addr; // held through tile_valid
		end
	end

endmodule

//--- design/vram_arbiter.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module vram_arbiter import pvr_pkg::*; (
	input  logic                     clock,
	input  logic                     reset_n,
	vram_rd_if.arbiter               ra,
	vram_rd_if.arbiter               lf,
	output logic                     vram_rd,
	output logic [`VRAM_PORT_AW-1:0] vram_addr,
	input  logic                     vram_wait,
	input  logic                     vram_valid,
	input  logic [`VRAM_BUS_W-1:0]   vram_din
);
	logic        busy;    // one read outstanding
	vram_owner_t owner;   // requester of the open read
	vram_owner_t last_q;  // last grant, for round robin
	logic        lane_q;  // upper half of the 64-bit word
	logic        free;
	logic        ra_win;
	logic        lf_win;
	logic [31:0] lane_data;

	assign free   = !busy && !vram_wait; // stall while the port is waiting
	assign ra_win = ra.req && (!lf.req || last_q == own_lf);
	assign lf_win = lf.req && !ra_win;

	assign ra.gnt = free && ra_win;
	assign lf.gnt = free && lf_win;

	assign vram_rd   = ra.gnt || lf.gnt;
	assign vram_addr = ra_win ? ra.addr[`VRAM_PORT_AW-1:0] : lf.addr[`VRAM_PORT_AW-1:0];

	// 4 MB and up lives in the upper lane
	assign lane_data = lane_q ? vram_din[`VRAM_BUS_W-1:32] : vram_din[31:0];

	assign ra.rdata  = lane_data;
	assign lf.rdata  = lane_data;
	assign ra.rvalid = busy && vram_valid && (owner == own_ra);
	assign lf.rvalid = busy && vram_valid && (owner == own_lf);

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			busy   <= 1'b0;
			owner  <= own_ra;
			last_q <= own_lf; // walker goes first after reset
			lane_q <= 1'b0;
		end else begin
			if (vram_rd) begin
				busy   <= 1'b1;
				owner  <= ra_win ? own_ra : own_lf;
				last_q <= ra_win ? own_ra : own_lf;
				lane_q <= ra_win ? ra.addr[`VRAM_PORT_AW] : lf.addr[`VRAM_PORT_AW];
			end else if (busy && vram_valid) begin
				busy <= 1'b0; // port free again next cycle
			end
		end
	end

endmodule

//--- design/vram_rd_if.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

interface vram_rd_if;
	logic                    req;    // held with addr until gnt
	logic [`VRAM_ADDR_W-1:0] addr;   // byte address, bit 22 picks the lane
	logic                    gnt;    // read accepted by the arbiter
	logic                    rvalid; // one pulse per grant
	logic [31:0]             rdata;  // selected half of the vram word

	modport requester (
		output req, addr,
		input  gnt, rvalid, rdata
	);

	modport arbiter (
		input  req, addr,
		output gnt, rvalid, rdata
	);
endinterface

//--- flist.f
+incdir+design
design/pvr_pkg.sv
design/vram_rd_if.sv
design/pvr_regs.sv
design/pal_ram.sv
design/region_walker.sv
design/list_fetcher.sv
design/vram_arbiter.sv
design/pvr_core.sv
verif/pvr_checker.sv
verif/pvr_tb.sv

//--- verif/pvr_checker.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module pvr_checker (
	input logic                   clock,
	input logic                   reset_n,
	input logic                   out_valid,
	input logic [5:0]             out_tile_x,
	input logic [5:0]             out_tile_y,
	input logic [`PVR_DATA_W-1:0] out_opb_word,
	input logic                   render_done
);
	logic [43:0] exp_q [$];              // {tile_x, tile_y, word} still to arrive
	string       test_name    = "startup";
	int          test_errs    = 0;
	int          total_errs   = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	int          checks       = 0;
	int          out_count    = 0;       // out_valid pulses since time zero
	int          done_count   = 0;       // render_done pulses since time zero

	function automatic void start_test(input string name);
		test_name = name;
		test_errs = 0;
		tests_run = tests_run + 1;
	endfunction

	function automatic void check_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		checks = checks + 1;
		if (exp !== act) begin
			$display("Fail %s: %s expected %0h actual %0h", test_name, what, exp, act);
			test_errs  = test_errs + 1;
			total_errs = total_errs + 1;
		end
	endfunction

	function automatic void report_problem(input string msg);
		$display("Error in %s: %s", test_name, msg); // not a value mismatch
		test_errs  = test_errs + 1;
		total_errs = total_errs + 1;
	endfunction

	function automatic void expect_tile(input logic [43:0] t);
		exp_q.push_back(t);
	endfunction

	function automatic void finish_test();
		if (exp_q.size() != 0) begin
			report_problem($sformatf("%0d expected tiles never came out", exp_q.size()));
			exp_q.delete();
		end
		if (test_errs == 0)
			$display("test %s passed", test_name);
		else begin
			$display("test %s failed with %0d errors", test_name, test_errs);
			tests_failed = tests_failed + 1;
		end
	endfunction

	function automatic int summary();
		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, checks, total_errs);
		return total_errs;
	endfunction

	// outputs are registered, mid-cycle they are settled
	always @(negedge clock) begin : watch
		logic [43:0] want;
		if (reset_n && out_valid) begin
			out_count = out_count + 1;
			if (exp_q.size() == 0)
				report_problem("output tile appeared with none left to expect");
			else begin
				want = exp_q.pop_front(); // strict order
				check_value("tile {x,y,word}", want, {out_tile_x, out_tile_y, out_opb_word});
			end
		end
		if (reset_n && render_done) begin
			done_count = done_count + 1;
			if (exp_q.size() != 0)
				report_problem("render_done came before the last tile");
		end
	end

endmodule

//--- verif/pvr_tb.sv
`timescale 1ns/1ps
`include "pvr_defines.svh"

module pvr_tb import pvr_pkg::*; ();
	logic                     clock;
	logic                     reset_n;
	logic                     pvr_reg_cs;
	logic [`PVR_ADDR_W-1:0]   pvr_addr;
	logic [`PVR_DATA_W-1:0]   pvr_din;
	logic                     pvr_rd;
	logic                     pvr_wr;
	logic [`PVR_DATA_W-1:0]   pvr_dout;
	logic                     vram_rd;
	logic [`VRAM_PORT_AW-1:0] vram_addr;
	logic                     vram_wait;
	logic                     vram_valid;
	logic [`VRAM_BUS_W-1:0]   vram_din;
	logic                     out_valid;
	logic [5:0]               out_tile_x;
	logic [5:0]               out_tile_y;
	logic [`PVR_DATA_W-1:0]   out_opb_word;
	logic                     out_credit;
	logic                     render_done;

	logic [31:0] lfsr_state = 32'h714d633e;
	logic [63:0] vram_mem [int]; // sparse store keyed by the 22-bit port address
	logic [43:0] ref_q [$];      // reference tiles in walk order
	bit          stress;         // random vram_wait and read delay
	bit          credit_on;      // consumer hands credits back

	pvr_core dut0 (.*);

	pvr_checker chk0 (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			lfsr_state = lfsr_step(lfsr_state);
			v          = {v[30:0], lfsr_state[0]}; // one step per bit
		end
	endtask

	function automatic logic [63:0] model_word(input logic [21:0] key);
		if (vram_mem.exists(int'(key)))
			return vram_mem[int'(key)];
		return {8'hA5, 2'b00, key, 8'h5A, 2'b00, key}; // untouched words differ per address
	endfunction

	// bit 22 of the byte address picks the half and bit 23 is lost on the port
	function automatic logic [31:0] half_word(input logic [23:0] a);
		logic [63:0] w;
		w = model_word(a[21:0]);
		return a[22] ? w[63:32] : w[31:0];
	endfunction

	function automatic void poke_word(input logic [23:0] a, input logic [31:0] d);
		logic [63:0] w;
		w = model_word(a[21:0]);
		if (a[22])
			w[63:32] = d;
		else
			w[31:0] = d;
		vram_mem[int'(a[21:0])] = w;
	endfunction

	// walks entries of control word and pointer word 8 bytes apart until the last one
	function automatic void expected_tiles(input logic [23:0] base);
		ra_ctrl_t    ctrl;
		logic [31:0] ptr;
		logic [23:0] a;
		int          guard;
		a     = base;
		guard = 0;
		ctrl  = '0;
		while (!ctrl.last && guard < 64) begin
			ctrl = half_word(a);
			ptr  = half_word(a + 24'd4);
			if (!ptr[31]) // bit 31 marks no opaque list
				ref_q.push_back({ctrl.tile_x, ctrl.tile_y, half_word(ptr[23:0])});
			a     = a + 24'd8;
			guard = guard + 1;
		end
	endfunction

	task automatic build_array(input logic [23:0] base, input int n,
		input logic [31:0] empty_mask, input logic [23:0] ptr_base);
		ra_ctrl_t    c;
		logic [23:0] ptr;
		logic [31:0] d;
		int          i;
		for (i = 0; i < n; i++) begin
			ptr = ptr_base + 24'(16 * (i / 2));
			if (i % 2)
				ptr = ptr + 24'h400000; // odd entries above 4 MB share the even one's word
			c        = '0;
			c.last   = (i == n - 1);
			c.tile_x = 6'(i + 3);
			c.tile_y = 6'(2 * i + 1);
			poke_word(base + 24'(8 * i), c);
			poke_word(base + 24'(8 * i) + 24'd4, {empty_mask[i], 7'h00, ptr});
			take_bits(32, d);
			poke_word(ptr, d);
		end
	endtask

	task automatic next_cycles(input int n);
		repeat (n) @(posedge clock);
		#2; // drive point
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
		pvr_reg_cs = 1'b1;
		pvr_wr     = 1'b1;
		pvr_addr   = a;
		pvr_din    = d;
		next_cycles(1); // taken at this edge
		pvr_reg_cs = 1'b0;
		pvr_wr     = 1'b0;
	endtask

	task automatic read_check(input string what, input logic [15:0] a, input logic [31:0] exp);
		logic [31:0] act;
		pvr_reg_cs = 1'b1;
		pvr_rd     = 1'b1;
		pvr_addr   = a;
		next_cycles(1);
		pvr_reg_cs = 1'b0;
		pvr_rd     = 1'b0;
		act        = pvr_dout; // one cycle of read latency
		chk0.check_value(what, exp, act);
	endtask

	task automatic launch_render(input logic [23:0] base);
		expected_tiles(base);
		while (ref_q.size() != 0)
			chk0.expect_tile(ref_q.pop_front());
		bus_write(`PVR_REGION_BASE_addr, {8'h00, base});
		bus_write(`PVR_STARTRENDER_addr, 32'h1);
	endtask

	task automatic wait_render_done(input int done0);
		int cycles;
		cycles = 0;
		while (chk0.done_count == done0 && cycles < 4000) begin
			next_cycles(1);
			cycles++;
		end
		if (chk0.done_count == done0)
			chk0.report_problem("render_done did not arrive within 4000 cycles");
		next_cycles(40); // a second pulse would show up here
		chk0.check_value("render_done pulses", 1, chk0.done_count - done0);
	endtask

	// vram read port that accepts only while vram_wait is low and replies in 0 to 3 cycles
	initial begin : vram_model
		logic [21:0] key;
		logic [31:0] dly;
		vram_valid = 1'b0;
		vram_din   = '0;
		forever begin
			@(negedge clock);
			if (vram_rd === 1'b1 && vram_wait === 1'b0) begin
				key = vram_addr;
				dly = 0;
				if (stress)
					take_bits(2, dly);
				@(posedge clock); // read issued here
				repeat (dly) @(posedge clock);
				#2;
				vram_din   = model_word(key);
				vram_valid = 1'b1;
				@(posedge clock);
				#2;
				vram_valid = 1'b0;
			end
		end
	end

	initial begin : wait_driver
		logic [31:0] b;
		vram_wait = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			if (stress) begin
				take_bits(1, b);
				vram_wait = b[0]; // stalls about half the cycles
			end else
				vram_wait = 1'b0;
		end
	end

	// consumer returns one credit per output while credit_on
	initial begin : consumer
		int pending;
		pending    = 0;
		out_credit = 1'b0;
		forever begin
			@(negedge clock);
			if (out_valid === 1'b1)
				pending++;
			@(posedge clock);
			#2;
			if (credit_on && pending > 0) begin
				out_credit = 1'b1;
				pending--;
			end else
				out_credit = 1'b0;
		end
	end

	initial begin : main
		logic [15:0] rw_addr [4];
		logic [31:0] rw_data [4];
		logic [9:0]  pal_idx [16];
		logic [31:0] pal_data [16];
		logic [31:0] v;
		int          i;
		int          done0;
		int          outs0;
		int          cycles;
		int          errs;
		pvr_reg_cs = 1'b0;
		pvr_addr   = '0;
		pvr_din    = '0;
		pvr_rd     = 1'b0;
		pvr_wr     = 1'b0;
		stress     = 1'b0;
		credit_on  = 1'b1;
		reset_n    = 1'b0;
		repeat (10) @(posedge clock);
		#2;
		reset_n = 1'b1;
		next_cycles(2);

		chk0.start_test("id_revision");
		read_check("ID", `PVR_ID_addr, `PVR_ID_VALUE);
		read_check("REVISION", `PVR_REVISION_addr, `PVR_REVISION_VALUE);
		bus_write(`PVR_ID_addr, 32'hFFFF_FFFF); // read-only so the write is dropped
		read_check("ID after write", `PVR_ID_addr, `PVR_ID_VALUE);
		chk0.finish_test();

		chk0.start_test("register_rw");
		rw_addr = '{`PVR_REGION_BASE_addr, `PVR_ISP_BACKGND_D_addr,
			`PVR_ISP_BACKGND_T_addr, `PVR_SOFTRESET_addr};
		for (i = 0; i < 4; i++) begin
			take_bits(32, rw_data[i]);
			bus_write(rw_addr[i], rw_data[i]);
		end
		for (i = 0; i < 4; i++)
			read_check($sformatf("reg %0h", rw_addr[i]), rw_addr[i], rw_data[i]);
		read_check("unmapped 0040", 16'h0040, 32'h0);
		chk0.finish_test();

		chk0.start_test("palette");
		for (i = 0; i < 16; i++) begin
			take_bits(6, v);
			pal_idx[i] = {4'(i), v[5:0]}; // distinct and spread over the whole RAM
			take_bits(32, pal_data[i]);
			bus_write({`PVR_PAL_PAGE, pal_idx[i], 2'b00}, pal_data[i]);
		end
		for (i = 0; i < 16; i++)
			read_check($sformatf("palette %0d", pal_idx[i]), {`PVR_PAL_PAGE, pal_idx[i], 2'b00},
				pal_data[i]);
		for (i = 0; i < 4; i++)
			read_check($sformatf("reg %0h after palette", rw_addr[i]), rw_addr[i], rw_data[i]);
		chk0.finish_test();

		chk0.start_test("render");
		build_array(24'h010000, 6, 32'b010010, 24'h020000); // entries 1 and 4 empty
		done0 = chk0.done_count;
		launch_render(24'h010000);
		wait_render_done(done0);
		chk0.finish_test();

		chk0.start_test("out_credit");
		build_array(24'h050000, 5, 32'h0, 24'h060000);
		credit_on = 1'b0; // hold every credit back
		done0     = chk0.done_count;
		outs0     = chk0.out_count;
		launch_render(24'h050000);
		cycles = 0;
		while (chk0.out_count - outs0 < `OUT_CREDITS && cycles < 2000) begin
			next_cycles(1);
			cycles++;
		end
		if (chk0.out_count - outs0 < `OUT_CREDITS)
			chk0.report_problem("first outputs did not arrive within 2000 cycles");
		next_cycles(60); // nothing more may come out here
		chk0.check_value("outputs without credit", `OUT_CREDITS, chk0.out_count - outs0);
		credit_on = 1'b1;
		wait_render_done(done0);
		chk0.finish_test();

		chk0.start_test("random_stall");
		take_bits(8, v);
		build_array(24'h070000, 8, v, 24'h080000);
		stress = 1'b1;
		done0  = chk0.done_count;
		launch_render(24'h070000);
		wait_render_done(done0);
		stress = 1'b0;
		chk0.finish_test();

		errs = chk0.summary();
		if (errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
